// File: hw/aib_params.svh
//--------------------
// Link build constants
// Channel count, widths, register map, delays
//--------------------
`ifndef AIB_PARAMS_SVH
`define AIB_PARAMS_SVH

// Link geometry
`define AIB_NUM_CHNL    4
`define AIB_HALF_W      19
`define AIB_PAD_W       40

// APB configuration port
`define AIB_ADDR_W      4
`define AIB_DATA_W      32
`define AIB_REG_CTRL    4'h0
`define AIB_REG_MASK    4'h4
`define AIB_REG_STATUS  4'h8

// Bring-up and flight time
`define AIB_POR_CYCLES  8
`define AIB_PAD_DLY     2

`endif

// File: hw/aib_pkg.sv
//--------------------
// Shared link types
// APB request, configuration, payload, pad word, pad bus
//--------------------
`include "aib_params.svh"

package aib_pkg;

    // APB request from the configuration master
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`AIB_ADDR_W-1:0] paddr;
        logic [`AIB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Settings from the register block
    typedef struct packed {
        logic                     conf_done;
        logic                     dbi_en;
        logic [`AIB_NUM_CHNL-1:0] chan_mask;
    } aib_cfg_t;

    // MAC payload of one channel, two inversion halves
    typedef struct packed {
        logic [`AIB_HALF_W-1:0] hi;
        logic [`AIB_HALF_W-1:0] lo;
    } aib_payload_t;

    // Pad word, hi flag on bit 39 and lo flag on bit 19
    typedef struct packed {
        logic                   hi_flag;
        logic [`AIB_HALF_W-1:0] hi;
        logic                   lo_flag;
        logic [`AIB_HALF_W-1:0] lo;
    } aib_pad_word_t;

    // All channels crossing the bridge
    typedef struct packed {
        aib_pad_word_t [`AIB_NUM_CHNL-1:0] word;
        logic [`AIB_NUM_CHNL-1:0]          valid;
    } aib_pad_bus_t;

endpackage

// File: hw/aib_cfg_regs.sv
//--------------------
// APB configuration registers
// CTRL and MASK read/write, STATUS read-only
// Zero-wait, no error response
//--------------------
`timescale 1ns/100ps
`include "aib_params.svh"

module aib_cfg_regs (
    input  logic                      dut_slave1,
    input  logic                      i_rst_n,
    input  aib_pkg::apb_req_t         i_apb,
    input  logic                      i_por,
    input  logic [`AIB_NUM_CHNL-1:0]  i_xfer_en,
    output logic [`AIB_DATA_W-1:0]    o_prdata,
    output aib_pkg::aib_cfg_t         o_cfg
);

    logic                     conf_done;
    logic                     dbi_en;
    logic [`AIB_NUM_CHNL-1:0] chan_mask;
    logic                     wr_access;

    // Write lands in the access phase
    assign wr_access = i_apb.psel & i_apb.penable & i_apb.pwrite;

    //--------------------
    // Register writes
    //--------------------
    always_ff @(posedge dut_slave1) begin
        if (!i_rst_n) begin
            conf_done <= 1'b0;
            dbi_en    <= 1'b0;
            chan_mask <= '0;
        end else if (wr_access) begin
            case (i_apb.paddr)
                `AIB_REG_CTRL: begin
                    conf_done <= i_apb.pwdata[0];
                    dbi_en    <= i_apb.pwdata[1];
                end
                `AIB_REG_MASK: begin
                    chan_mask <= i_apb.pwdata[`AIB_NUM_CHNL-1:0];
                end
                default: begin
                    // Unmapped or read-only, nothing stored
                end
            endcase
        end
    end

    //--------------------
    // Read mux
    //--------------------
    always_comb begin
        o_prdata = '0;
        if (i_apb.psel) begin
            case (i_apb.paddr)
                `AIB_REG_CTRL: begin
                    o_prdata[1:0] = {dbi_en, conf_done};
                end
                `AIB_REG_MASK: begin
                    o_prdata[`AIB_NUM_CHNL-1:0] = chan_mask;
                end
                `AIB_REG_STATUS: begin
                    // por in bit 0, transfer enables in 7:4
                    o_prdata[0]   = i_por;
                    o_prdata[7:4] = i_xfer_en;
                end
                default: begin
                    o_prdata = '0;
                end
            endcase
        end
    end

    assign o_cfg.conf_done = conf_done;
    assign o_cfg.dbi_en    = dbi_en;
    assign o_cfg.chan_mask = chan_mask;

    // Access phase always follows a selected setup phase
    a_penable_psel: assert property (
        @(posedge dut_slave1) disable iff (!i_rst_n)
        i_apb.penable |-> i_apb.psel
    );

endmodule

// File: hw/aib_bringup.sv
//--------------------
// Link bring-up sequencer
// Power-on reset release counter
// Per-channel transfer enables
//--------------------
`timescale 1ns/100ps
`include "aib_params.svh"

module aib_bringup (
    input  logic                      dut_slave1,
    input  logic                      i_rst_n,
    input  aib_pkg::aib_cfg_t         i_cfg,
    input  logic [`AIB_NUM_CHNL-1:0]  i_adapter_rstn,
    input  logic                      i_ms_mac_rdy,
    input  logic                      i_sl_mac_rdy,
    output logic                      o_por,
    output logic [`AIB_NUM_CHNL-1:0]  o_xfer_en
);

    localparam int CNT_W = $clog2(`AIB_POR_CYCLES + 1);

    logic [CNT_W-1:0]         por_cnt;
    logic [`AIB_NUM_CHNL-1:0] chan_ready;

    //--------------------
    // POR release
    //--------------------
    always_ff @(posedge dut_slave1) begin
        if (!i_rst_n) begin
            por_cnt <= '0;
            o_por   <= 1'b1;
        end else if (!i_cfg.conf_done) begin
            // Withdrawn configuration restarts the count
            por_cnt <= '0;
            o_por   <= 1'b1;
        end else if (por_cnt != CNT_W'(`AIB_POR_CYCLES - 1)) begin
            por_cnt <= por_cnt + 1'b1;
        end else begin
            o_por <= 1'b0;
        end
    end

    //--------------------
    // Transfer enables
    //--------------------
    // Both MACs ready and the adapter out of reset on an unmasked channel
    assign chan_ready = i_cfg.chan_mask & i_adapter_rstn &
                        {`AIB_NUM_CHNL{i_ms_mac_rdy & i_sl_mac_rdy}};

    always_ff @(posedge dut_slave1) begin
        if (!i_rst_n) begin
            o_xfer_en <= '0;
        end else if (o_por || !i_cfg.conf_done) begin
            // conf_done term drops enables in step with por rising
            o_xfer_en <= '0;
        end else begin
            o_xfer_en <= chan_ready;
        end
    end

    // Enables never overlap power-on reset
    a_no_xfer_in_por: assert property (
        @(posedge dut_slave1) disable iff (!i_rst_n)
        o_por |-> (o_xfer_en == '0)
    );

endmodule

// File: hw/aib_tx_chan.sv
//--------------------
// Transmit channel encoder
// Data bus inversion per half, pad word register
//--------------------
`timescale 1ns/100ps
`include "aib_params.svh"

module aib_tx_chan (
    input  logic                   dut_slave1,
    input  logic                   i_rst_n,
    input  logic                   i_dbi_en,
    input  logic                   i_xfer_en,
    input  logic                   i_valid,
    input  aib_pkg::aib_payload_t  i_payload,
    output logic                   o_valid,
    output aib_pkg::aib_pad_word_t o_pad
);

    // Invert a half once more than half its bits are ones
    localparam int ONES_MAX = `AIB_HALF_W / 2;

    logic inv_lo;
    logic inv_hi;

    assign inv_lo = i_dbi_en && ($countones(i_payload.lo) > ONES_MAX);
    assign inv_hi = i_dbi_en && ($countones(i_payload.hi) > ONES_MAX);

    //--------------------
    // Pad word
    //--------------------
    always_ff @(posedge dut_slave1) begin
        o_pad.lo      <= inv_lo ? ~i_payload.lo : i_payload.lo;
        o_pad.lo_flag <= inv_lo;
        o_pad.hi      <= inv_hi ? ~i_payload.hi : i_payload.hi;
        o_pad.hi_flag <= inv_hi;
    end

    // Words offered on a disabled channel are dropped
    always_ff @(posedge dut_slave1) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & i_xfer_en;
        end
    end

    // Channel still enabled while its valid pad word is on the pads
    a_tx_only_enabled: assert property (
        @(posedge dut_slave1) disable iff (!i_rst_n)
        o_valid |-> i_xfer_en
    );

endmodule

// File: hw/aib_pad_delay.sv
//--------------------
// Pad and bridge flight time
// Fixed-depth pipeline of any payload type
//--------------------
`timescale 1ns/100ps

module aib_pad_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic dut_slave1,
    input  logic i_rst_n,
    input  T     i_data,
    output T     o_data
);

    T pipe [DEPTH];

    always_ff @(posedge dut_slave1) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= i_data;
            // Each stage is one cycle of flight
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign o_data = pipe[DEPTH-1];

endmodule

// File: hw/aib_rx_chan.sv
//--------------------
// Receive channel decoder
// Undo inversion per half, gate with receive enable
//--------------------
`timescale 1ns/100ps

module aib_rx_chan (
    input  logic                   dut_slave1,
    input  logic                   i_rst_n,
    input  logic                   i_rx_en,
    input  logic                   i_valid,
    input  aib_pkg::aib_pad_word_t i_pad,
    output logic                   o_valid,
    output aib_pkg::aib_payload_t  o_payload
);

    aib_pkg::aib_payload_t decoded;

    // Flag set means the half crossed inverted
    assign decoded.lo = i_pad.lo_flag ? ~i_pad.lo : i_pad.lo;
    assign decoded.hi = i_pad.hi_flag ? ~i_pad.hi : i_pad.hi;

    //--------------------
    // Output register
    //--------------------
    always_ff @(posedge dut_slave1) begin
        o_payload <= decoded;
    end

    always_ff @(posedge dut_slave1) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            // Delayed enable closes the window at the far side too
            o_valid <= i_valid & i_rx_en;
        end
    end

endmodule

// File: hw/aib_link_top.sv
//--------------------
// Die-to-die link top
// Config, bring-up, channel encoders and decoders
// Pad and bridge pipeline between the two sides
//--------------------
`timescale 1ns/100ps
`include "aib_params.svh"

module aib_link_top (
    input  logic                                         dut_slave1,
    input  logic                                         i_rst_n,
    input  aib_pkg::apb_req_t                            i_apb,
    output logic [`AIB_DATA_W-1:0]                       o_prdata,
    input  logic [`AIB_NUM_CHNL-1:0]                     i_adapter_rstn,
    input  logic                                         i_ms_mac_rdy,
    input  logic                                         i_sl_mac_rdy,
    input  logic [`AIB_NUM_CHNL-1:0]                     i_tx_valid,
    input  aib_pkg::aib_payload_t [`AIB_NUM_CHNL-1:0]    i_tx_payload,
    output logic [`AIB_NUM_CHNL-1:0]                     o_rx_valid,
    output aib_pkg::aib_payload_t [`AIB_NUM_CHNL-1:0]    o_rx_payload,
    output aib_pkg::aib_pad_word_t [`AIB_NUM_CHNL-1:0]   o_pad_data,
    output logic [`AIB_NUM_CHNL-1:0]                     o_pad_valid,
    output logic                                         o_por,
    output logic [`AIB_NUM_CHNL-1:0]                     o_xfer_en,
    output logic                                         o_conf_done
);

    aib_pkg::aib_cfg_t                          cfg;
    aib_pkg::aib_pad_word_t [`AIB_NUM_CHNL-1:0] tx_word;
    logic [`AIB_NUM_CHNL-1:0]                   tx_valid;
    aib_pkg::aib_pad_bus_t                      tx_bus;
    aib_pkg::aib_pad_bus_t                      rx_bus;
    logic [`AIB_NUM_CHNL-1:0]                   rx_en;

    //--------------------
    // Configuration and bring-up
    //--------------------
    aib_cfg_regs u_cfg_regs (
        .dut_slave1 (dut_slave1),
        .i_rst_n    (i_rst_n),
        .i_apb      (i_apb),
        .i_por      (o_por),
        .i_xfer_en  (o_xfer_en),
        .o_prdata   (o_prdata),
        .o_cfg      (cfg)
    );

    aib_bringup u_bringup (
        .dut_slave1     (dut_slave1),
        .i_rst_n        (i_rst_n),
        .i_cfg          (cfg),
        .i_adapter_rstn (i_adapter_rstn),
        .i_ms_mac_rdy   (i_ms_mac_rdy),
        .i_sl_mac_rdy   (i_sl_mac_rdy),
        .o_por          (o_por),
        .o_xfer_en      (o_xfer_en)
    );

    assign o_conf_done  = cfg.conf_done;
    assign tx_bus.word  = tx_word;
    assign tx_bus.valid = tx_valid;
    assign o_pad_data   = tx_word;
    assign o_pad_valid  = tx_valid;

    //--------------------
    // Bridge
    //--------------------
    aib_pad_delay #(.T(aib_pkg::aib_pad_bus_t), .DEPTH(`AIB_PAD_DLY)) u_pad_bus (
        .dut_slave1 (dut_slave1),
        .i_rst_n    (i_rst_n),
        .i_data     (tx_bus),
        .o_data     (rx_bus)
    );

    // Enables travel alongside the data
    aib_pad_delay #(.T(logic [`AIB_NUM_CHNL-1:0]), .DEPTH(`AIB_PAD_DLY)) u_pad_en (
        .dut_slave1 (dut_slave1),
        .i_rst_n    (i_rst_n),
        .i_data     (o_xfer_en),
        .o_data     (rx_en)
    );

    //--------------------
    // Channels
    //--------------------
    for (genvar c = 0; c < `AIB_NUM_CHNL; c++) begin : g_chan
        aib_tx_chan u_tx (
            .dut_slave1 (dut_slave1),
            .i_rst_n    (i_rst_n),
            .i_dbi_en   (cfg.dbi_en),
            .i_xfer_en  (o_xfer_en[c]),
            .i_valid    (i_tx_valid[c]),
            .i_payload  (i_tx_payload[c]),
            .o_valid    (tx_valid[c]),
            .o_pad      (tx_word[c])
        );

        aib_rx_chan u_rx (
            .dut_slave1 (dut_slave1),
            .i_rst_n    (i_rst_n),
            .i_rx_en    (rx_en[c]),
            .i_valid    (rx_bus.valid[c]),
            .i_pad      (rx_bus.word[c]),
            .o_valid    (o_rx_valid[c]),
            .o_payload  (o_rx_payload[c])
        );
    end

endmodule

// File: verif/tb_clk_gen.sv
//--------------------
// Testbench clock and reset
// 20 ns period, reset low for five cycles
//--------------------
`timescale 1ns/100ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Release just after the fifth rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

// File: verif/tb_aib_link.sv
//--------------------
// Link testbench
// Runs the stimulus file, APB and bring-up checks
// Scoreboard for pad words and received payloads
//--------------------
`timescale 1ns/100ps
`include "aib_params.svh"

module tb_aib_link;

    typedef struct packed {
        logic [31:0]            due;
        logic [1:0]             chan;
        logic                   valid;
        aib_pkg::aib_pad_word_t pad;
        aib_pkg::aib_payload_t  payload;
    } word_exp_t;

    logic                                       dut_slave1;
    logic                                       rst_n;
    aib_pkg::apb_req_t                          apb;
    logic [`AIB_DATA_W-1:0]                     prdata;
    logic [`AIB_NUM_CHNL-1:0]                   adapter_rstn;
    logic                                       ms_rdy;
    logic                                       sl_rdy;
    logic [`AIB_NUM_CHNL-1:0]                   tx_valid;
    aib_pkg::aib_payload_t [`AIB_NUM_CHNL-1:0]  tx_payload;
    logic [`AIB_NUM_CHNL-1:0]                   rx_valid;
    aib_pkg::aib_payload_t [`AIB_NUM_CHNL-1:0]  rx_payload;
    aib_pkg::aib_pad_word_t [`AIB_NUM_CHNL-1:0] pad_data;
    logic [`AIB_NUM_CHNL-1:0]                   pad_valid;
    logic                                       por;
    logic [`AIB_NUM_CHNL-1:0]                   xfer_en;
    logic                                       conf_done;

    int        err_cnt = 0;
    int        cyc = 0;
    logic      mon_en = 1'b0;
    logic      dbi = 1'b0;
    logic      conf_exp = 1'b0;
    logic      lines_loaded = 1'b0;
    string     line_q[$];
    word_exp_t pad_q[$];
    word_exp_t rx_q[$];

    tb_clk_gen u_clk_gen (.o_clk(dut_slave1), .o_rst_n(rst_n));

    aib_link_top UUT (
        .dut_slave1     (dut_slave1),
        .i_rst_n        (rst_n),
        .i_apb          (apb),
        .o_prdata       (prdata),
        .i_adapter_rstn (adapter_rstn),
        .i_ms_mac_rdy   (ms_rdy),
        .i_sl_mac_rdy   (sl_rdy),
        .i_tx_valid     (tx_valid),
        .i_tx_payload   (tx_payload),
        .o_rx_valid     (rx_valid),
        .o_rx_payload   (rx_payload),
        .o_pad_data     (pad_data),
        .o_pad_valid    (pad_valid),
        .o_por          (por),
        .o_xfer_en      (xfer_en),
        .o_conf_done    (conf_done)
    );

    // Halves with more than nine ones cross inverted, flag set
    function automatic logic [`AIB_PAD_W-1:0] dbi_encode(input logic [37:0] pl, input logic en);
        logic [`AIB_HALF_W-1:0] hi;
        logic [`AIB_HALF_W-1:0] lo;
        logic                   hi_inv;
        logic                   lo_inv;
        hi = pl[37:19];
        lo = pl[18:0];
        hi_inv = en && ($countones(hi) > 9);
        lo_inv = en && ($countones(lo) > 9);
        return {hi_inv, hi_inv ? ~hi : hi, lo_inv, lo_inv ? ~lo : lo};
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge dut_slave1);
        #1;
    endtask

    //--------------------
    // APB master
    //--------------------
    task automatic apb_write(input logic [`AIB_ADDR_W-1:0] addr, input logic [31:0] data);
        apb.psel    = 1'b1;
        apb.pwrite  = 1'b1;
        apb.penable = 1'b0;
        apb.paddr   = addr;
        apb.pwdata  = data;
        next_cycle();
        apb.penable = 1'b1;
        next_cycle();
        apb = '0;
    endtask

    task automatic apb_read_check(input logic [`AIB_ADDR_W-1:0] addr, input logic [31:0] exp);
        apb.psel    = 1'b1;
        apb.pwrite  = 1'b0;
        apb.penable = 1'b0;
        apb.paddr   = addr;
        apb.pwdata  = '0;
        next_cycle();
        apb.penable = 1'b1;
        #5;
        check_value(64'(prdata), 64'(exp), $sformatf("read of register %0h", addr));
        next_cycle();
        apb = '0;
    endtask

    //--------------------
    // Data words
    //--------------------
    // Pad word one cycle on, payload four cycles on if accepted
    task automatic queue_word(input logic [1:0] chan, input logic [37:0] pl,
                              input logic [39:0] pad, input logic acc);
        word_exp_t e;
        e.due     = cyc + 1;
        e.chan    = chan;
        e.valid   = acc;
        e.pad     = pad;
        e.payload = pl;
        pad_q.push_back(e);
        if (acc) begin
            e.due = cyc + `AIB_PAD_DLY + 2;
            rx_q.push_back(e);
        end
        tx_valid[chan]   = 1'b1;
        tx_payload[chan] = pl;
    endtask

    task automatic send_random(input int count, input logic [3:0] mask);
        logic [63:0] r;
        for (int n = 0; n < count; n++) begin
            for (int c = 0; c < `AIB_NUM_CHNL; c++) begin
                r = {$urandom(), $urandom()};
                queue_word(2'(c), r[37:0], dbi_encode(r[37:0], dbi), mask[c]);
            end
            next_cycle();
        end
        tx_valid = '0;
    endtask

    task automatic por_release(input logic [63:0] exp);
        int cnt;
        cnt = 0;
        while (por === 1'b1 && cnt < 4 * `AIB_POR_CYCLES) begin
            next_cycle();
            cnt++;
        end
        check_value(64'(cnt), exp, "cycles to por release");
    endtask

    always @(posedge dut_slave1) begin
        cyc <= cyc + 1;
    end

    // Scoreboard sampled late in the cycle
    always @(posedge dut_slave1) begin
        logic [`AIB_NUM_CHNL-1:0] rx_exp;
        logic [`AIB_NUM_CHNL-1:0] pad_seen;
        word_exp_t                e;
        #15;
        if (mon_en) begin
            pad_seen = '0;
            rx_exp   = '0;
            while (pad_q.size() > 0 && pad_q[0].due == cyc) begin
                e = pad_q.pop_front();
                pad_seen[e.chan] = 1'b1;
                check_value(64'(pad_data[e.chan]), 64'(e.pad), "pad word");
                check_value(64'(pad_valid[e.chan]), 64'(e.valid), "pad valid");
            end
            check_value(64'(pad_valid & ~pad_seen), 64'd0, "unexpected pad valid");
            while (rx_q.size() > 0 && rx_q[0].due == cyc) begin
                e = rx_q.pop_front();
                rx_exp[e.chan] = 1'b1;
                check_value(64'(rx_payload[e.chan]), 64'(e.payload), "rx payload");
            end
            check_value(64'(rx_valid), 64'(rx_exp), "rx valid");
        end
    end

    //--------------------
    // Stimulus runner
    //--------------------
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  cmd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] d;
        apb          = '0;
        adapter_rstn = '0;
        ms_rdy       = 1'b0;
        sl_rdy       = 1'b0;
        tx_valid     = '0;
        tx_payload   = '0;
        void'($urandom(32'h4bb7));
        fd = $fopen("verif/aib_stimulus.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("Could not open the stimulus file verif/aib_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    line_q.push_back(line);
                end
            end
            $fclose(fd);
            lines_loaded = 1'b1;
            wait (rst_n === 1'b1);
            next_cycle();
            mon_en = 1'b1;
            foreach (line_q[i]) begin
                line = line_q[i];
                cmd  = line.getc(0);
                case (cmd)
                    "W": begin
                        n = $sscanf(line, "W %h %h", a, b);
                        if (a[3:0] == `AIB_REG_CTRL) begin
                            dbi      = b[1];
                            conf_exp = b[0];
                        end
                        apb_write(a[3:0], b[31:0]);
                    end
                    "R": begin
                        n = $sscanf(line, "R %h %h", a, b);
                        apb_read_check(a[3:0], b[31:0]);
                    end
                    "C": begin
                        n = $sscanf(line, "C %h %h %h", a, b, c);
                        adapter_rstn = a[3:0];
                        ms_rdy       = b[0];
                        sl_rdy       = c[0];
                    end
                    "S": begin
                        n = $sscanf(line, "S %h %h", a, b);
                        check_value(64'(por), 64'(a[0]), "por");
                        check_value(64'(xfer_en), 64'(b[3:0]), "transfer enables");
                        check_value(64'(conf_done), 64'(conf_exp), "conf done");
                    end
                    "P": begin
                        n = $sscanf(line, "P %h", a);
                        por_release(a);
                    end
                    "T": begin
                        n = $sscanf(line, "T %h", a);
                        repeat (int'(a)) next_cycle();
                    end
                    "D": begin
                        n = $sscanf(line, "D %h %h %h %h", a, b, c, d);
                        queue_word(a[1:0], b[37:0], c[39:0], d[0]);
                        next_cycle();
                        tx_valid = '0;
                    end
                    "F": begin
                        n = $sscanf(line, "F %h %h", a, b);
                        send_random(int'(a), b[3:0]);
                    end
                    "#", "\n", "\r", " ": begin
                    end
                    default: begin
                        err_cnt++;
                        $display("Stimulus line %0d has an unknown command: %s", i + 1, line);
                    end
                endcase
            end
            repeat (8) next_cycle();
            if (pad_q.size() != 0 || rx_q.size() != 0) begin
                err_cnt++;
                $display("Words never arrived: %0d pad, %0d received", pad_q.size(), rx_q.size());
            end
        end
        $display("Checks done with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog allows fifty cycles per stimulus line
    initial begin
        wait (lines_loaded);
        repeat (line_q.size() * 50) @(posedge dut_slave1);
        $display("Run did not finish in time, %0d errors so far", err_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verif/aib_stimulus.txt
# W addr data | R addr expect | C adapter_rstn ms_rdy sl_rdy | S por xfer_en | P por_cycles
# T cycles | D chan payload pad accept | F cycles accept_mask (random on all channels), all hex
S 1 0
R 0 0
R 4 0
R 8 1
W C FFFFFFFF
R C 0
W 4 F
R 4 F
C F 1 1
W 0 1
P 8
S 0 0
T 1
S 0 F
R 0 1
R 8 F0
C E 1 1
T 1
S 0 E
C F 0 1
T 1
S 0 0
C F 1 1
T 1
S 0 F
W 4 5
T 1
S 0 5
D 0 3FFFFFFFFF 7FFFF7FFFF 1
D 1 FF803FF 1FF003FF 0
W 0 3
D 2 3FFFFFFFFF 8000080000 1
D 2 0 0 1
D 2 FF803FF 1FFFFC00 1
D 2 1FF801FF FFC00001FF 1
D 0 1FF801FF FFC00001FF 1
D 1 0 0 0
T 6
F 4 5
W 0 1
F 3 5
W 4 F
T 1
S 0 F
F 2 F
C 7 1 1
T 1
S 0 7
D 3 3FFFFFFFFF 7FFFF7FFFF 0
F 2 7
T 6
W 0 0
T 1
S 1 0
R 8 1
W 0 3
P 8
T 1
S 0 7
R 8 70
D 1 3FFFFFFFFF 8000080000 1
T 6

// File: files.f
+incdir+hw
hw/aib_pkg.sv
hw/aib_cfg_regs.sv
hw/aib_bringup.sv
hw/aib_tx_chan.sv
hw/aib_pad_delay.sv
hw/aib_rx_chan.sv
hw/aib_link_top.sv
verif/tb_clk_gen.sv
verif/tb_aib_link.sv

// File: Makefile
TB_TOP = tb_aib_link

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module aib_link_top
	verilator --lint-only --timing -f files.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
